/* hw/ooo_defs.svh */
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Reorder buffer entries as a power of two
`define ROB_DEPTH 8

`define REG_NUM 32

// Cycles from multiplier accept to result
`define MUL_CYCLES 4

`endif

/* hw/ooo_pkg.sv */
`include "ooo_defs.svh"

package ooo_pkg;

typedef logic [31:0] word_t;

typedef logic [4:0] reg_addr_t;

typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_index_t;

typedef enum logic [2:0] {
	OP_ADD = 3'd0,
	OP_SUB = 3'd1,
	OP_AND = 3'd2,
	OP_OR  = 3'd3,
	OP_XOR = 3'd4,
	OP_SLT = 3'd5,
	OP_MUL = 3'd6
} op_t;

// Execution unit that takes an op
typedef enum logic {
	UNIT_ALU = 1'b0,
	UNIT_MUL = 1'b1
} unit_sel_t;

endpackage

/* hw/dispatch.sv */
`timescale 1ns/1ps

module dispatch(
	input  logic                issue_valid,
	input  ooo_pkg::op_t        issue_op,
	input  ooo_pkg::reg_addr_t  issue_dest,
	input  ooo_pkg::word_t      issue_a,
	input  ooo_pkg::word_t      issue_b,
	output logic                issue_ready,
	input  logic                rob_full,
	input  ooo_pkg::rob_index_t alloc_tag,
	output logic                rob_alloc,
	output ooo_pkg::reg_addr_t  rob_alloc_dest,
	output logic                alu_valid,
	input  logic                alu_ready,
	output logic                mul_valid,
	input  logic                mul_ready,
	output ooo_pkg::op_t        unit_op,
	output ooo_pkg::word_t      unit_a,
	output ooo_pkg::word_t      unit_b,
	output ooo_pkg::rob_index_t unit_tag
);

ooo_pkg::unit_sel_t unit_sel;
logic               unit_ready;
logic               fire;

assign unit_sel   = (issue_op == ooo_pkg::OP_MUL) ? ooo_pkg::UNIT_MUL : ooo_pkg::UNIT_ALU;
assign unit_ready = (unit_sel == ooo_pkg::UNIT_MUL) ? mul_ready : alu_ready;

// Both the ROB and the chosen unit must take the op in the same cycle
assign issue_ready = ~rob_full & unit_ready;
assign fire        = issue_valid & issue_ready;

assign rob_alloc      = fire;
assign rob_alloc_dest = issue_dest;

assign alu_valid = fire & (unit_sel == ooo_pkg::UNIT_ALU);
assign mul_valid = fire & (unit_sel == ooo_pkg::UNIT_MUL);

assign unit_op  = issue_op;
assign unit_a   = issue_a;
assign unit_b   = issue_b;
assign unit_tag = alloc_tag;

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit(
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	output logic                in_ready,
	input  ooo_pkg::op_t        in_op,
	input  ooo_pkg::word_t      in_a,
	input  ooo_pkg::word_t      in_b,
	input  ooo_pkg::rob_index_t in_tag,
	output logic                res_valid,
	input  logic                res_ready,
	output ooo_pkg::rob_index_t res_tag,
	output ooo_pkg::word_t      res_data
);

ooo_pkg::word_t result;
logic           accept;

always_comb begin
	unique case (in_op)
		ooo_pkg::OP_ADD: result = in_a + in_b;
		ooo_pkg::OP_SUB: result = in_a - in_b;
		ooo_pkg::OP_AND: result = in_a & in_b;
		ooo_pkg::OP_OR:  result = in_a | in_b;
		ooo_pkg::OP_XOR: result = in_a ^ in_b;
		ooo_pkg::OP_SLT: result = {31'b0, $signed(in_a) < $signed(in_b)};
		default:         result = '0;
	endcase
end

// Hold slot frees up on the same edge it is granted
assign in_ready = ~res_valid | res_ready;
assign accept   = in_valid & in_ready;

always_ff @(posedge clk) begin
	if (rst) begin
		res_valid <= 1'b0;
	end else if (accept) begin
		res_valid <= 1'b1;
	end else if (res_ready) begin
		res_valid <= 1'b0;
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		res_tag  <= in_tag;
		res_data <= result;
	end
end

// Dispatch only offers an op when the hold slot can take it
assert property (@(posedge clk) disable iff (rst) in_valid |-> in_ready);

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/1ps
`include "ooo_defs.svh"

module mul_unit(
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	output logic                in_ready,
	input  ooo_pkg::word_t      in_a,
	input  ooo_pkg::word_t      in_b,
	input  ooo_pkg::rob_index_t in_tag,
	output logic                res_valid,
	input  logic                res_ready,
	output ooo_pkg::rob_index_t res_tag,
	output ooo_pkg::word_t      res_data
);

// Multiplier bits consumed per cycle
localparam int STEP = 32 / `MUL_CYCLES;

logic                               busy;
logic [$clog2(`MUL_CYCLES+1)-1:0]   count;
ooo_pkg::word_t                     acc;
ooo_pkg::word_t                     mcand;
ooo_pkg::word_t                     mplier;
logic                               accept;

assign in_ready = ~busy;
assign accept   = in_valid & in_ready;

always_ff @(posedge clk) begin
	if (rst) begin
		busy      <= 1'b0;
		count     <= '0;
		res_valid <= 1'b0;
	end else begin
		if (accept) begin
			busy  <= 1'b1;
			count <= `MUL_CYCLES;
		end else if (count != '0) begin
			count <= count - 1'b1;
			if (count == 1)
				res_valid <= 1'b1;
		end else if (res_valid && res_ready) begin
			busy      <= 1'b0;
			res_valid <= 1'b0;
		end
	end
end

// Shift-add of one multiplier chunk per cycle
always_ff @(posedge clk) begin
	if (accept) begin
		acc     <= '0;
		mcand   <= in_a;
		mplier  <= in_b;
		res_tag <= in_tag;
	end else if (count != '0) begin
		acc    <= acc + mcand * mplier[STEP-1:0];
		mcand  <= mcand << STEP;
		mplier <= mplier >> STEP;
	end
end

assign res_data = acc;

// Dispatch must see in_ready low for the whole busy window
assert property (@(posedge clk) disable iff (rst) busy |-> !in_valid);

endmodule

/* hw/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter(
	input  logic                clk,
	input  logic                rst,
	input  logic                alu_res_valid,
	output logic                alu_res_ready,
	input  ooo_pkg::rob_index_t alu_res_tag,
	input  ooo_pkg::word_t      alu_res_data,
	input  logic                mul_res_valid,
	output logic                mul_res_ready,
	input  ooo_pkg::rob_index_t mul_res_tag,
	input  ooo_pkg::word_t      mul_res_data,
	output logic                cdb_valid,
	output ooo_pkg::rob_index_t cdb_tag,
	output ooo_pkg::word_t      cdb_data
);

// Multiplier wins since it has waited longer for its result
assign mul_res_ready = mul_res_valid;
assign alu_res_ready = alu_res_valid & ~mul_res_valid;

assign cdb_valid = alu_res_valid | mul_res_valid;

always_comb begin
	if (mul_res_valid) begin
		cdb_tag  = mul_res_tag;
		cdb_data = mul_res_data;
	end else begin
		cdb_tag  = alu_res_tag;
		cdb_data = alu_res_data;
	end
end

// A result that loses the bus is offered again unchanged
assert property (@(posedge clk) disable iff (rst)
	alu_res_valid && !alu_res_ready |=>
		alu_res_valid && $stable(alu_res_tag) && $stable(alu_res_data));

endmodule

/* hw/rob.sv */
`timescale 1ns/1ps
`include "ooo_defs.svh"

module rob(
	input  logic                clk,
	input  logic                rst,
	input  logic                alloc,
	input  ooo_pkg::reg_addr_t  alloc_dest,
	output ooo_pkg::rob_index_t alloc_tag,
	output logic                full,
	input  logic                cdb_valid,
	input  ooo_pkg::rob_index_t cdb_tag,
	input  ooo_pkg::word_t      cdb_data,
	output logic                commit_valid,
	output ooo_pkg::reg_addr_t  commit_dest,
	output ooo_pkg::word_t      commit_data
);

logic [`ROB_DEPTH-1:0]           valid_q;
logic [`ROB_DEPTH-1:0]           complete_q;
ooo_pkg::reg_addr_t              dest_q [`ROB_DEPTH];
ooo_pkg::word_t                  data_q [`ROB_DEPTH];
ooo_pkg::rob_index_t             head;
ooo_pkg::rob_index_t             tail;
logic [$clog2(`ROB_DEPTH+1)-1:0] count;

assign full      = (count == `ROB_DEPTH);
assign alloc_tag = tail;

// Head retires as soon as its result has landed
assign commit_valid = valid_q[head] & complete_q[head];
assign commit_dest  = dest_q[head];
assign commit_data  = data_q[head];

always_ff @(posedge clk) begin
	if (rst) begin
		valid_q    <= '0;
		complete_q <= '0;
		head       <= '0;
		tail       <= '0;
		count      <= '0;
	end else begin
		if (alloc) begin
			valid_q[tail]    <= 1'b1;
			complete_q[tail] <= 1'b0;
			tail             <= tail + 1'b1;
		end
		if (cdb_valid)
			complete_q[cdb_tag] <= 1'b1;
		if (commit_valid) begin
			valid_q[head] <= 1'b0;
			head          <= head + 1'b1;
		end
		case ({alloc, commit_valid})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (alloc)
		dest_q[tail] <= alloc_dest;
	if (cdb_valid)
		data_q[cdb_tag] <= cdb_data;
end

assert property (@(posedge clk) disable iff (rst) alloc |-> !full);

// A result on the bus must belong to an op still in flight
assert property (@(posedge clk) disable iff (rst) cdb_valid |-> valid_q[cdb_tag]);

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps
`include "ooo_defs.svh"

module regfile(
	input  logic               clk,
	input  logic               rst,
	input  logic               we,
	input  ooo_pkg::reg_addr_t waddr,
	input  ooo_pkg::word_t     wdata,
	input  ooo_pkg::reg_addr_t raddr,
	output ooo_pkg::word_t     rdata
);

ooo_pkg::word_t regs [`REG_NUM];

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `REG_NUM; i++)
			regs[i] <= '0;
	end else if (we && waddr != '0) begin
		regs[waddr] <= wdata;
	end
end

// Register 0 is cleared by reset and never written
assign rdata = regs[raddr];

endmodule

/* hw/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core(
	input  logic               clk,
	input  logic               rst,
	input  logic               issue_valid,
	input  ooo_pkg::op_t       issue_op,
	input  ooo_pkg::reg_addr_t issue_dest,
	input  ooo_pkg::word_t     issue_a,
	input  ooo_pkg::word_t     issue_b,
	output logic               issue_ready,
	output logic               commit_valid,
	output ooo_pkg::reg_addr_t commit_dest,
	output ooo_pkg::word_t     commit_data,
	input  ooo_pkg::reg_addr_t rd_addr,
	output ooo_pkg::word_t     rd_data
);

// ROB allocation
logic                rob_alloc;
logic                rob_full;
ooo_pkg::reg_addr_t  rob_alloc_dest;
ooo_pkg::rob_index_t alloc_tag;

// Dispatch to units
logic                alu_valid, alu_ready;
logic                mul_valid, mul_ready;
ooo_pkg::op_t        unit_op;
ooo_pkg::word_t      unit_a, unit_b;
ooo_pkg::rob_index_t unit_tag;

// Unit results
logic                alu_res_valid, alu_res_ready;
ooo_pkg::rob_index_t alu_res_tag;
ooo_pkg::word_t      alu_res_data;
logic                mul_res_valid, mul_res_ready;
ooo_pkg::rob_index_t mul_res_tag;
ooo_pkg::word_t      mul_res_data;

// CDB
logic                cdb_valid;
ooo_pkg::rob_index_t cdb_tag;
ooo_pkg::word_t      cdb_data;

dispatch dispatch_inst(
	.issue_valid,
	.issue_op,
	.issue_dest,
	.issue_a,
	.issue_b,
	.issue_ready,
	.rob_full,
	.alloc_tag,
	.rob_alloc,
	.rob_alloc_dest,
	.alu_valid,
	.alu_ready,
	.mul_valid,
	.mul_ready,
	.unit_op,
	.unit_a,
	.unit_b,
	.unit_tag
);

alu_unit alu_unit_inst(
	.clk,
	.rst,
	.in_valid  ( alu_valid     ),
	.in_ready  ( alu_ready     ),
	.in_op     ( unit_op       ),
	.in_a      ( unit_a        ),
	.in_b      ( unit_b        ),
	.in_tag    ( unit_tag      ),
	.res_valid ( alu_res_valid ),
	.res_ready ( alu_res_ready ),
	.res_tag   ( alu_res_tag   ),
	.res_data  ( alu_res_data  )
);

mul_unit mul_unit_inst(
	.clk,
	.rst,
	.in_valid  ( mul_valid     ),
	.in_ready  ( mul_ready     ),
	.in_a      ( unit_a        ),
	.in_b      ( unit_b        ),
	.in_tag    ( unit_tag      ),
	.res_valid ( mul_res_valid ),
	.res_ready ( mul_res_ready ),
	.res_tag   ( mul_res_tag   ),
	.res_data  ( mul_res_data  )
);

cdb_arbiter cdb_arbiter_inst(
	.clk,
	.rst,
	.alu_res_valid,
	.alu_res_ready,
	.alu_res_tag,
	.alu_res_data,
	.mul_res_valid,
	.mul_res_ready,
	.mul_res_tag,
	.mul_res_data,
	.cdb_valid,
	.cdb_tag,
	.cdb_data
);

rob rob_inst(
	.clk,
	.rst,
	.alloc      ( rob_alloc      ),
	.alloc_dest ( rob_alloc_dest ),
	.alloc_tag,
	.full       ( rob_full       ),
	.cdb_valid,
	.cdb_tag,
	.cdb_data,
	.commit_valid,
	.commit_dest,
	.commit_data
);

regfile regfile_inst(
	.clk,
	.rst,
	.we    ( commit_valid ),
	.waddr ( commit_dest  ),
	.wdata ( commit_data  ),
	.raddr ( rd_addr      ),
	.rdata ( rd_data      )
);

endmodule

/* dv/ooo_core_tb.sv */
`timescale 1ns/1ps
`include "ooo_defs.svh"

module ooo_core_tb;

localparam int          NUM_OPS   = 22;
localparam int          TIMEOUT   = NUM_OPS * (`MUL_CYCLES + 10) + 200;
localparam string       STIM_FILE = "dv/ooo_stim.txt";
localparam logic [31:0] SEED      = 32'habb7c77d;

logic               clk;
logic               rst;
logic               issue_valid;
ooo_pkg::op_t       issue_op;
ooo_pkg::reg_addr_t issue_dest;
ooo_pkg::word_t     issue_a;
ooo_pkg::word_t     issue_b;
logic               issue_ready;
logic               commit_valid;
ooo_pkg::reg_addr_t commit_dest;
ooo_pkg::word_t     commit_data;
ooo_pkg::reg_addr_t rd_addr;
ooo_pkg::word_t     rd_data;

// Five words per op in file order
logic [31:0] stim [NUM_OPS*5];

// Ops accepted but not yet committed, oldest first
ooo_pkg::reg_addr_t ref_dest [$];
ooo_pkg::word_t     ref_data [$];
ooo_pkg::word_t     shadow [`REG_NUM];
ooo_pkg::reg_addr_t exp_dest;
ooo_pkg::word_t     exp_data;

int mismatches   = 0;
int other_errors = 0;
int issued       = 0;
int committed    = 0;
int stall_cycles = 0;
int cycles       = 0;

ooo_core ooo_core_inst(.*);

initial clk = 1'b0;
always #4 clk = ~clk;

task automatic finish_run();
	$display("errors: %0d mismatches, %0d other (issued %0d, committed %0d, stalled %0d cycles)",
		mismatches, other_errors, issued, committed, stall_cycles);
	if (mismatches == 0 && other_errors == 0)
		$display("Simulation PASSED");
	else
		$display("Simulation FAILED");
	$finish;
endtask

// Starts and ends on a falling edge
task automatic issue_one(input int idx);
	int gap;
	int base;
	gap  = $urandom % 3;
	base = idx * 5;
	repeat (gap) @(negedge clk);
	issue_valid = 1'b1;
	issue_op    = ooo_pkg::op_t'(stim[base][2:0]);
	issue_dest  = stim[base+1][4:0];
	issue_a     = stim[base+2];
	issue_b     = stim[base+3];
	@(posedge clk);
	while (!issue_ready) begin
		stall_cycles++;
		@(posedge clk);
	end
	ref_dest.push_back(stim[base+1][4:0]);
	ref_data.push_back(stim[base+4]);
	issued++;
	@(negedge clk);
	issue_valid = 1'b0;
endtask

task automatic check_registers();
	for (int r = 0; r < `REG_NUM; r++) begin
		rd_addr = 5'(r);
		@(posedge clk);
		if (rd_data !== shadow[r]) begin
			mismatches++;
			$display("mismatch reg_r%0d: expected %08h, actual %08h", r, shadow[r], rd_data);
		end
		@(negedge clk);
	end
endtask

always @(posedge clk) begin
	if (!rst && commit_valid) begin
		if (ref_dest.size() == 0) begin
			other_errors++;
			$display("commit seen with no op outstanding, dest r%0d", commit_dest);
		end else begin
			exp_dest = ref_dest.pop_front();
			exp_data = ref_data.pop_front();
			if (commit_dest !== exp_dest) begin
				mismatches++;
				$display("mismatch commit_%0d dest: expected %0d, actual %0d",
					committed, exp_dest, commit_dest);
			end
			if (commit_data !== exp_data) begin
				mismatches++;
				$display("mismatch commit_%0d data: expected %08h, actual %08h",
					committed, exp_data, commit_data);
			end
			// r0 keeps zero no matter what commits to it
			if (exp_dest != '0)
				shadow[exp_dest] = exp_data;
		end
		committed++;
	end
end

always @(posedge clk) begin
	cycles++;
	if (cycles >= TIMEOUT) begin
		other_errors++;
		$display("timeout after %0d cycles, %0d of %0d ops committed", cycles, committed, NUM_OPS);
		finish_run();
	end
end

initial begin
	void'($urandom(SEED));
	rst         = 1'b1;
	issue_valid = 1'b0;
	issue_op    = ooo_pkg::OP_ADD;
	issue_dest  = '0;
	issue_a     = '0;
	issue_b     = '0;
	rd_addr     = '0;
	for (int r = 0; r < `REG_NUM; r++)
		shadow[r] = '0;
	$readmemh(STIM_FILE, stim);
	if ($isunknown(stim[0])) begin
		other_errors++;
		$display("stimulus file could not be read");
		finish_run();
	end else begin
		repeat (8) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < NUM_OPS; i++)
			issue_one(i);
		wait (committed == NUM_OPS);
		@(negedge clk);
		check_registers();
		if (stall_cycles == 0) begin
			other_errors++;
			$display("issue_ready never dropped while ops were waiting");
		end
		if (committed != issued) begin
			other_errors++;
			$display("commit count %0d differs from issue count %0d", committed, issued);
		end
		finish_run();
	end
end

endmodule

/* dv/ooo_stim.txt */
// op dest a b expected, all hex
// op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 mul
6 01 00000003 00000007 00000015
0 02 00000005 0000000a 0000000f
1 03 00000005 00000007 fffffffe
2 04 f0f0ff00 0ff0f0f0 00f0f000
3 05 f0000000 0000000f f000000f
4 06 aaaa5555 ffff0000 55555555
5 07 ffffffff 00000001 00000001
5 08 00000001 ffffffff 00000000
0 00 12345678 00000001 12345679
6 09 00012345 00010000 23450000
6 0a ffffffff 00000002 fffffffe
6 0b 12345678 00000010 23456780
6 0c 0000ffff 0000ffff fffe0001
0 01 ffffffff 00000001 00000000
1 0d 00000000 00000001 ffffffff
5 0e 80000000 7fffffff 00000001
4 0f 12345678 12345678 00000000
3 02 0000ff00 000000ff 0000ffff
2 10 ffffffff 13579bdf 13579bdf
6 11 00000007 fffffff9 ffffffcf
0 12 00000064 000000c8 0000012c
0 13 7fffffff 00000001 80000000

/* sources.f */
+incdir+hw
hw/ooo_pkg.sv
hw/dispatch.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/cdb_arbiter.sv
hw/rob.sv
hw/regfile.sv
hw/ooo_core.sv
dv/ooo_core_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module ooo_core_tb -o sim_ooo
	./obj_dir/sim_ooo | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
